/* block_xcrypt_top.f */
source/block_xcrypt_pkg.sv
source/block_xcrypt_ctrl.sv
source/block_fetch.sv
source/block_store.sv
source/block_drain.sv
source/block_xcrypt_top.sv
verif/block_xcrypt_assertions.sv
verif/block_xcrypt_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the block transformer testbench with Verilator and run it.
# A failing check ends the run with $fatal, which gives a nonzero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing \
  --top-module block_xcrypt_tb \
  -Mdir obj_dir \
  -f block_xcrypt_top.f

# Raised error limit lets the testbench see assertion failures and end the run itself
./obj_dir/Vblock_xcrypt_tb +verilator+error+limit+100

/* source/block_drain.sv */
// Wishbone block write master

module block_drain
  import block_xcrypt_pkg::*;
#(
  parameter int WB_ADDR_W = 32
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 start_i,
  input  addr_t                base_i,
  input  word_t                rdata_i,
  input  logic                 wbw_ack_i,
  output word_idx_t            ridx_o,
  output logic                 wbw_cyc_o,
  output logic                 wbw_stb_o,
  output logic                 wbw_we_o,
  output logic [WB_ADDR_W-1:0] wbw_adr_o,
  output word_t                wbw_dat_o,
  output logic                 done_o
);

  logic      busy_q;
  logic      cyc_q;
  logic      done_q;
  word_idx_t idx_q;
  addr_t     base_q;
  addr_t     word_addr;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q <= 1'b0;
      cyc_q  <= 1'b0;
      done_q <= 1'b0;
      idx_q  <= '0;
      base_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (!busy_q) begin
        if (start_i) begin
          busy_q <= 1'b1;
          cyc_q  <= 1'b1;
          idx_q  <= '0;
          base_q <= base_i;
        end
      end else if (cyc_q) begin
        if (wbw_ack_i) begin
          cyc_q <= 1'b0;
          if (idx_q == word_idx_t'(BLOCK_WORDS - 1)) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end else begin
            idx_q <= idx_q + 1'b1;
          end
        end
      end else begin
        cyc_q <= 1'b1;
      end
    end
  end

  assign word_addr = base_q + addr_t'({idx_q, 2'b00});

  // Index is registered, so the store output stays put until ack
  assign ridx_o    = idx_q;
  assign wbw_dat_o = rdata_i;

  assign wbw_cyc_o = cyc_q;
  assign wbw_stb_o = cyc_q;
  assign wbw_we_o  = cyc_q;
  assign wbw_adr_o = word_addr[WB_ADDR_W-1:0];
  assign done_o    = done_q;

endmodule

/* source/block_fetch.sv */
// Wishbone block read master

module block_fetch
  import block_xcrypt_pkg::*;
#(
  parameter int WB_ADDR_W = 32
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 start_i,
  input  addr_t                base_i,
  input  word_t                wbr_dat_i,
  input  logic                 wbr_ack_i,
  output logic                 wbr_cyc_o,
  output logic                 wbr_stb_o,
  output logic [WB_ADDR_W-1:0] wbr_adr_o,
  output logic                 store_we_o,
  output word_idx_t            store_idx_o,
  output word_t                store_wdata_o,
  output logic                 done_o
);

  logic      busy_q;
  logic      cyc_q;
  logic      done_q;
  word_idx_t idx_q;
  addr_t     base_q;
  addr_t     word_addr;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q <= 1'b0;
      cyc_q  <= 1'b0;
      done_q <= 1'b0;
      idx_q  <= '0;
      base_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (!busy_q) begin
        if (start_i) begin
          busy_q <= 1'b1;
          cyc_q  <= 1'b1;
          idx_q  <= '0;
          base_q <= base_i;
        end
      end else if (cyc_q) begin
        if (wbr_ack_i) begin
          // One idle cycle follows every word
          cyc_q <= 1'b0;
          if (idx_q == word_idx_t'(BLOCK_WORDS - 1)) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end else begin
            idx_q <= idx_q + 1'b1;
          end
        end
      end else begin
        cyc_q <= 1'b1;
      end
    end
  end

  assign word_addr = base_q + addr_t'({idx_q, 2'b00});

  assign wbr_cyc_o = cyc_q;
  assign wbr_stb_o = cyc_q;
  assign wbr_adr_o = word_addr[WB_ADDR_W-1:0];

  // Returned word goes into the store on the ack cycle
  assign store_we_o    = cyc_q & wbr_ack_i;
  assign store_idx_o   = idx_q;
  assign store_wdata_o = wbr_dat_i;
  assign done_o        = done_q;

endmodule

/* source/block_store.sv */
// Block buffer with key whitening

module block_store
  import block_xcrypt_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  key_t      key_i,
  input  logic      we_i,
  input  word_idx_t widx_i,
  input  word_t     wdata_i,
  input  word_idx_t ridx_i,
  output word_t     rdata_o
);

  key_t  key_q;
  word_t words_q [BLOCK_WORDS];
  word_t key_word;

  // Key is taken with the first word of each block
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key_q <= '0;
    end else if (we_i && widx_i == '0) begin
      key_q <= key_i;
    end
  end

  always_ff @(posedge clk) begin
    if (we_i) begin
      words_q[widx_i] <= wdata_i;
    end
  end

  // Key word k sits at bits 32k+31 down to 32k
  assign key_word = key_q[ridx_i*32 +: 32];

  assign rdata_o = words_q[ridx_i] ^ key_word;

endmodule

/* source/block_xcrypt_ctrl.sv */
// Block sequencing controller

module block_xcrypt_ctrl
  import block_xcrypt_pkg::*;
(
  input  logic  clk,
  input  logic  reset_n,
  input  logic  start_i,
  input  addr_t src_addr_i,
  input  addr_t dst_addr_i,
  input  len_t  byte_len_i,
  input  logic  fetch_done_i,
  input  logic  drain_done_i,
  output logic  fetch_start_o,
  output addr_t fetch_base_o,
  output logic  drain_start_o,
  output addr_t drain_base_o,
  output logic  done_o
);

  xcrypt_state_t state_q, state_d;

  len_t  rem_len_q;
  len_t  blk_cnt_q;
  addr_t src_base_q;
  addr_t dst_base_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= XC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Job bookkeeping, loaded once and advanced per block
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rem_len_q  <= '0;
      blk_cnt_q  <= '0;
      src_base_q <= '0;
      dst_base_q <= '0;
    end else if (state_q == XC_STARTING) begin
      rem_len_q  <= byte_len_i;
      blk_cnt_q  <= '0;
      src_base_q <= src_addr_i;
      dst_base_q <= dst_addr_i;
    end else if (state_q == XC_BLOCK_DONE) begin
      // Saturate so a partial last block ends at zero
      rem_len_q <= (rem_len_q > BLOCK_BYTES) ? rem_len_q - BLOCK_BYTES : '0;
      blk_cnt_q <= blk_cnt_q + 1'b1;
    end
  end

  // Both bases step by one block per completed block
  assign fetch_base_o = src_base_q + addr_t'(blk_cnt_q * BLOCK_BYTES);
  assign drain_base_o = dst_base_q + addr_t'(blk_cnt_q * BLOCK_BYTES);

  always_comb begin
    state_d = state_q;
    case (state_q)
      XC_IDLE: begin
        if (start_i) begin
          state_d = XC_STARTING;
        end
      end
      XC_STARTING: begin
        // Empty job skips all bus traffic
        state_d = (byte_len_i == '0) ? XC_BLOCK_DONE : XC_FETCH;
      end
      XC_FETCH: begin
        state_d = XC_FETCH_WAIT;
      end
      XC_FETCH_WAIT: begin
        if (fetch_done_i) begin
          state_d = XC_WORKING;
        end
      end
      XC_WORKING: begin
        // Whitening happens on store read-out
        state_d = XC_DRAIN;
      end
      XC_DRAIN: begin
        state_d = XC_DRAIN_WAIT;
      end
      XC_DRAIN_WAIT: begin
        if (drain_done_i) begin
          state_d = XC_BLOCK_DONE;
        end
      end
      XC_BLOCK_DONE: begin
        state_d = (rem_len_q <= BLOCK_BYTES) ? XC_FINISHED : XC_FETCH;
      end
      XC_FINISHED: begin
        state_d = XC_IDLE;
      end
      default: begin
        state_d = XC_IDLE;
      end
    endcase
  end

  // Single-cycle strobes straight from the state
  always_comb begin
    fetch_start_o = 1'b0;
    drain_start_o = 1'b0;
    done_o        = 1'b0;
    case (state_q)
      XC_FETCH:    fetch_start_o = 1'b1;
      XC_DRAIN:    drain_start_o = 1'b1;
      XC_FINISHED: done_o        = 1'b1;
      default:     ;
    endcase
  end

endmodule

/* source/block_xcrypt_pkg.sv */
// Block transformer shared types
// Widths, controller states and block geometry

package block_xcrypt_pkg;

  // Bus and configuration widths
  typedef logic [31:0]  word_t;
  typedef logic [31:0]  addr_t;
  typedef logic [31:0]  len_t;
  typedef logic [127:0] key_t;

  // Word position inside one block
  typedef logic [1:0]   word_idx_t;

  // Number of words and bytes in one block
  localparam int unsigned BLOCK_WORDS = 4;
  localparam int unsigned BLOCK_BYTES = BLOCK_WORDS * 4;

  // Controller sequence, one pass per block
  typedef enum logic [3:0] {
    XC_IDLE,
    XC_STARTING,
    XC_FETCH,
    XC_FETCH_WAIT,
    XC_WORKING,
    XC_DRAIN,
    XC_DRAIN_WAIT,
    XC_BLOCK_DONE,
    XC_FINISHED
  } xcrypt_state_t;

endpackage

/* source/block_xcrypt_top.sv */
// Block transformer top level

module block_xcrypt_top
  import block_xcrypt_pkg::*;
#(
  parameter int WB_ADDR_W = 32
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 start_i,
  input  addr_t                src_addr_i,
  input  addr_t                dst_addr_i,
  input  len_t                 byte_len_i,
  input  key_t                 key_i,
  output logic                 done_o,
  // Source read port
  output logic                 wbr_cyc_o,
  output logic                 wbr_stb_o,
  output logic [WB_ADDR_W-1:0] wbr_adr_o,
  input  word_t                wbr_dat_i,
  input  logic                 wbr_ack_i,
  // Destination write port
  output logic                 wbw_cyc_o,
  output logic                 wbw_stb_o,
  output logic                 wbw_we_o,
  output logic [WB_ADDR_W-1:0] wbw_adr_o,
  output word_t                wbw_dat_o,
  input  logic                 wbw_ack_i
);

  logic      fetch_start;
  addr_t     fetch_base;
  logic      fetch_done;
  logic      drain_start;
  addr_t     drain_base;
  logic      drain_done;
  logic      store_we;
  word_idx_t store_idx;
  word_t     store_wdata;
  word_idx_t store_ridx;
  word_t     store_rdata;

  block_xcrypt_ctrl ctrl0 (
    .clk           (clk),
    .reset_n       (reset_n),
    .start_i       (start_i),
    .src_addr_i    (src_addr_i),
    .dst_addr_i    (dst_addr_i),
    .byte_len_i    (byte_len_i),
    .fetch_done_i  (fetch_done),
    .drain_done_i  (drain_done),
    .fetch_start_o (fetch_start),
    .fetch_base_o  (fetch_base),
    .drain_start_o (drain_start),
    .drain_base_o  (drain_base),
    .done_o        (done_o)
  );

  block_fetch #(
    .WB_ADDR_W (WB_ADDR_W)
  ) fetch0 (
    .clk           (clk),
    .reset_n       (reset_n),
    .start_i       (fetch_start),
    .base_i        (fetch_base),
    .wbr_dat_i     (wbr_dat_i),
    .wbr_ack_i     (wbr_ack_i),
    .wbr_cyc_o     (wbr_cyc_o),
    .wbr_stb_o     (wbr_stb_o),
    .wbr_adr_o     (wbr_adr_o),
    .store_we_o    (store_we),
    .store_idx_o   (store_idx),
    .store_wdata_o (store_wdata),
    .done_o        (fetch_done)
  );

  block_store store0 (
    .clk     (clk),
    .reset_n (reset_n),
    .key_i   (key_i),
    .we_i    (store_we),
    .widx_i  (store_idx),
    .wdata_i (store_wdata),
    .ridx_i  (store_ridx),
    .rdata_o (store_rdata)
  );

  block_drain #(
    .WB_ADDR_W (WB_ADDR_W)
  ) drain0 (
    .clk       (clk),
    .reset_n   (reset_n),
    .start_i   (drain_start),
    .base_i    (drain_base),
    .rdata_i   (store_rdata),
    .wbw_ack_i (wbw_ack_i),
    .ridx_o    (store_ridx),
    .wbw_cyc_o (wbw_cyc_o),
    .wbw_stb_o (wbw_stb_o),
    .wbw_we_o  (wbw_we_o),
    .wbw_adr_o (wbw_adr_o),
    .wbw_dat_o (wbw_dat_o),
    .done_o    (drain_done)
  );

endmodule

/* verif/block_xcrypt_assertions.sv */
// Bus protocol and data checks
// Bound to the block transformer top

module block_xcrypt_assertions
  import block_xcrypt_pkg::*;
#(
  parameter int WB_ADDR_W = 32
) (
  input logic                 clk,
  input logic                 reset_n,
  input logic                 start_i,
  input addr_t                src_addr_i,
  input addr_t                dst_addr_i,
  input len_t                 byte_len_i,
  input key_t                 key_i,
  input logic                 done_i,
  input logic                 wbr_cyc_i,
  input logic                 wbr_stb_i,
  input logic [WB_ADDR_W-1:0] wbr_adr_i,
  input logic                 wbr_ack_i,
  input logic                 wbw_cyc_i,
  input logic                 wbw_stb_i,
  input logic                 wbw_we_i,
  input logic [WB_ADDR_W-1:0] wbw_adr_i,
  input word_t                wbw_dat_i,
  input logic                 wbw_ack_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;

  addr_t      src_q;
  addr_t      dst_q;
  len_t       len_q;
  key_t       key_q;
  logic       job_q;
  len_t       rd_cnt;
  len_t       wr_cnt;
  logic [7:0] since_start;
  len_t       exp_words;
  addr_t      exp_rd_adr;
  addr_t      exp_wr_adr;
  word_t      exp_wr_dat;

  // Source memory content is the byte address with a fixed mask
  function automatic word_t src_pattern(input addr_t a);
    return a ^ 32'h5a5a0000;
  endfunction

  // Job configuration and word counters, restarted by each start pulse
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      src_q       <= '0;
      dst_q       <= '0;
      len_q       <= '0;
      key_q       <= '0;
      job_q       <= 1'b0;
      rd_cnt      <= '0;
      wr_cnt      <= '0;
      since_start <= '0;
    end else if (start_i) begin
      src_q       <= src_addr_i;
      dst_q       <= dst_addr_i;
      len_q       <= byte_len_i;
      key_q       <= key_i;
      job_q       <= 1'b1;
      rd_cnt      <= '0;
      wr_cnt      <= '0;
      since_start <= 8'd1;
    end else begin
      if (done_i) begin
        job_q <= 1'b0;
      end
      if (wbr_cyc_i && wbr_stb_i && wbr_ack_i) begin
        rd_cnt <= rd_cnt + 32'd1;
      end
      if (wbw_cyc_i && wbw_stb_i && wbw_ack_i) begin
        wr_cnt <= wr_cnt + 32'd1;
      end
      if (since_start != 8'hff) begin
        since_start <= since_start + 8'd1;
      end
    end
  end

  // Word n of block b sits 16b plus 4n bytes past the base
  assign exp_words  = ((len_q + 32'd15) >> 4) << 2;
  assign exp_rd_adr = src_q + (rd_cnt << 2);
  assign exp_wr_adr = dst_q + (wr_cnt << 2);
  assign exp_wr_dat = src_pattern(src_q + (wr_cnt << 2)) ^ key_q[{wr_cnt[1:0], 5'b00000} +: 32];

  a_rd_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (wbr_stb_i && !wbr_ack_i) |=> (wbr_stb_i && $stable(wbr_adr_i)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Read strobe dropped or address moved before ack");
    end

  a_wr_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (wbw_stb_i && !wbw_ack_i) |=>
      (wbw_stb_i && $stable(wbw_adr_i) && $stable(wbw_dat_i) && $stable(wbw_we_i)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Write strobe dropped or address, data or we moved before ack");
    end

  a_stb_cyc: assert property (@(posedge clk) disable iff (!reset_n)
    (wbr_stb_i |-> wbr_cyc_i) and (wbw_stb_i |-> wbw_cyc_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Strobe high while cyc is low");
    end

  a_rd_adr: assert property (@(posedge clk) disable iff (!reset_n)
    wbr_stb_i |-> wbr_adr_i == exp_rd_adr[WB_ADDR_W-1:0])
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAILED wbr_adr_o: got %h expected %h", wbr_adr_i, exp_rd_adr[WB_ADDR_W-1:0]);
    end

  a_wr_adr: assert property (@(posedge clk) disable iff (!reset_n)
    wbw_stb_i |-> wbw_adr_i == exp_wr_adr[WB_ADDR_W-1:0])
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAILED wbw_adr_o: got %h expected %h", wbw_adr_i, exp_wr_adr[WB_ADDR_W-1:0]);
    end

  a_wr_dat: assert property (@(posedge clk) disable iff (!reset_n)
    wbw_stb_i |-> wbw_dat_i == exp_wr_dat)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAILED wbw_dat_o: got %h expected %h", wbw_dat_i, exp_wr_dat);
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    done_i |=> !done_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("done_o stayed high for more than one cycle");
    end

  a_ack_count: assert property (@(posedge clk) disable iff (!reset_n)
    done_i |-> (rd_cnt == exp_words && wr_cnt == exp_words))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAILED ack count: read %h write %h expected %h", rd_cnt, wr_cnt, exp_words);
    end

  a_ack_excess: assert property (@(posedge clk) disable iff (!reset_n)
    ((wbr_cyc_i && wbr_stb_i && wbr_ack_i) |-> rd_cnt < exp_words) and
    ((wbw_cyc_i && wbw_stb_i && wbw_ack_i) |-> wr_cnt < exp_words))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("More bus words acknowledged than the job length needs");
    end

  // No bus traffic outside a job, none at all for an empty one
  a_idle_bus: assert property (@(posedge clk) disable iff (!reset_n)
    (!job_q || len_q == '0) |-> !(wbr_cyc_i || wbw_cyc_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Bus cycle outside a job or during a zero length job");
    end

  a_zero_len: assert property (@(posedge clk) disable iff (!reset_n)
    (done_i && len_q == '0) |-> since_start == 8'd3)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("FAILED done_o delay: got %h expected %h", since_start, 8'd3);
    end

  a_reset: assert property (@(posedge clk)
    (!reset_n || $rose(reset_n)) |->
      !(wbr_cyc_i || wbr_stb_i || wbw_cyc_i || wbw_stb_i || wbw_we_i || done_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("Bus or done output high in or right after reset");
    end

endmodule

bind block_xcrypt_top block_xcrypt_assertions #(
  .WB_ADDR_W (WB_ADDR_W)
) chk0 (
  .clk        (clk),
  .reset_n    (reset_n),
  .start_i    (start_i),
  .src_addr_i (src_addr_i),
  .dst_addr_i (dst_addr_i),
  .byte_len_i (byte_len_i),
  .key_i      (key_i),
  .done_i     (done_o),
  .wbr_cyc_i  (wbr_cyc_o),
  .wbr_stb_i  (wbr_stb_o),
  .wbr_adr_i  (wbr_adr_o),
  .wbr_ack_i  (wbr_ack_i),
  .wbw_cyc_i  (wbw_cyc_o),
  .wbw_stb_i  (wbw_stb_o),
  .wbw_we_i   (wbw_we_o),
  .wbw_adr_i  (wbw_adr_o),
  .wbw_dat_i  (wbw_dat_o),
  .wbw_ack_i  (wbw_ack_i)
);

/* verif/block_xcrypt_tb.sv */
// Block transformer testbench

module block_xcrypt_tb
  import block_xcrypt_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int JOB_TIMEOUT = 4000;
  localparam int RANDOM_JOBS = 8;

  logic        clk = 1'b0;
  logic        reset_n = 1'b0;
  logic        start = 1'b0;
  addr_t       src_addr = '0;
  addr_t       dst_addr = '0;
  len_t        byte_len = '0;
  key_t        key = '0;
  logic        done;
  logic        wbr_cyc;
  logic        wbr_stb;
  addr_t       wbr_adr;
  word_t       wbr_dat = '0;
  logic        wbr_ack = 1'b0;
  logic        wbw_cyc;
  logic        wbw_stb;
  logic        wbw_we;
  addr_t       wbw_adr;
  word_t       wbw_dat;
  logic        wbw_ack = 1'b0;
  logic [1:0]  rd_delay = 2'd0;
  logic [1:0]  wr_delay = 2'd0;
  logic [31:0] lfsr_state = 32'h8324ff69;

  block_xcrypt_top dut0 (
    .clk        (clk),
    .reset_n    (reset_n),
    .start_i    (start),
    .src_addr_i (src_addr),
    .dst_addr_i (dst_addr),
    .byte_len_i (byte_len),
    .key_i      (key),
    .done_o     (done),
    .wbr_cyc_o  (wbr_cyc),
    .wbr_stb_o  (wbr_stb),
    .wbr_adr_o  (wbr_adr),
    .wbr_dat_i  (wbr_dat),
    .wbr_ack_i  (wbr_ack),
    .wbw_cyc_o  (wbw_cyc),
    .wbw_stb_o  (wbw_stb),
    .wbw_we_o   (wbw_we),
    .wbw_adr_o  (wbw_adr),
    .wbw_dat_o  (wbw_dat),
    .wbw_ack_i  (wbw_ack)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic random_key(output key_t k);
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
      rand_bits(32, r);
      k[i*32 +: 32] = r;
    end
  endtask

  function automatic word_t src_pattern(input addr_t a);
    return a ^ 32'h5a5a0000;
  endfunction

  // Source memory with a random ack delay per word
  always @(posedge clk) begin : src_mem_model
    logic [31:0] r;
    if (!reset_n) begin
      wbr_ack  <= 1'b0;
      rd_delay <= 2'd0;
    end else begin
      wbr_ack <= 1'b0;
      if (wbr_cyc && wbr_stb && !wbr_ack) begin
        if (rd_delay == 2'd0) begin
          wbr_ack <= 1'b1;
          wbr_dat <= src_pattern(wbr_adr);
          rand_bits(2, r);
          rd_delay <= r[1:0];
        end else begin
          rd_delay <= rd_delay - 2'd1;
        end
      end
    end
  end

  always @(posedge clk) begin : dst_mem_model
    logic [31:0] r;
    if (!reset_n) begin
      wbw_ack  <= 1'b0;
      wr_delay <= 2'd0;
    end else begin
      wbw_ack <= 1'b0;
      if (wbw_cyc && wbw_stb && wbw_we && !wbw_ack) begin
        if (wr_delay == 2'd0) begin
          wbw_ack <= 1'b1;
          rand_bits(2, r);
          wr_delay <= r[1:0];
        end else begin
          wr_delay <= wr_delay - 2'd1;
        end
      end
    end
  end

  // Stop at the first assertion failure
  always @(negedge clk) begin
    if (dut0.chk0.fail_cnt != 0) begin
      $display("ERRORS FOUND");
      $fatal(1, "An assertion on the DUT failed");
    end
  end

  task automatic run_job(input addr_t s_addr, input addr_t d_addr, input len_t n_bytes,
                         input key_t k);
    int cycles;
    @(posedge clk);
    start    <= 1'b1;
    src_addr <= s_addr;
    dst_addr <= d_addr;
    byte_len <= n_bytes;
    key      <= k;
    @(posedge clk);
    start <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!done) begin
      @(negedge clk);
      cycles = cycles + 1;
      if (cycles > JOB_TIMEOUT) begin
        $display("ERRORS FOUND");
        $fatal(1, "Timed out waiting for done_o on a job of %0d bytes", n_bytes);
      end
    end
    repeat (2) @(posedge clk);
  endtask

  initial begin : stimulus
    key_t        k;
    logic [31:0] r;
    addr_t       s_addr;
    addr_t       d_addr;
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;
    @(posedge clk);

    // Empty, whole, partial and multi-block jobs
    random_key(k);
    run_job(32'h0000_1000, 32'h0000_8000, 32'd0, k);
    run_job(32'h0000_1000, 32'h0000_8000, 32'd16, k);
    random_key(k);
    run_job(32'h0000_2004, 32'h0000_9010, 32'd5, k);
    run_job(32'h0000_3000, 32'h0000_a000, 32'd48, k);
    run_job(32'h0000_3000, 32'h0000_a000, 32'd0, k);

    for (int j = 0; j < RANDOM_JOBS; j++) begin
      random_key(k);
      rand_bits(14, r);
      s_addr = {16'h0001, r[13:0], 2'b00};
      rand_bits(14, r);
      d_addr = {16'h0002, r[13:0], 2'b00};
      rand_bits(7, r);
      run_job(s_addr, d_addr, {25'd0, r[6:0]}, k);
    end

    repeat (4) @(posedge clk);
    if (dut0.chk0.fail_cnt != 0) begin
      $display("ERRORS FOUND");
      $fatal(1, "Assertion failures were reported during the run");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule
